// File: filelist.f
+incdir+hdl
hdl/rf_pkg.sv
hdl/bus_pkg.sv
hdl/lockstep_delay.sv
hdl/reg_file.sv
hdl/rf_access_ctrl.sv
hdl/lockstep_checker.sv
hdl/core_shell_top.sv
verification/core_shell_asserts.sv
verification/core_shell_tb.sv

// File: hdl/bus_pkg.sv
/*
 * Wishbone transaction and control state types
 */
`include "core_shell_params.svh"

package bus_pkg;

  // Byte address seen on the bus
  typedef logic [`CS_WB_AW-1:0] wb_addr_t;

  // One select bit per data byte
  typedef logic [`CS_XLEN/8-1:0] wb_sel_t;

  // Slave control state
  // RESP is the single cycle that carries ack or err
  typedef enum logic {
    IDLE = 1'b0,
    RESP = 1'b1
  } bus_state_e;

endpackage

// File: hdl/core_shell_params.svh
/*
 * Core shell sizes and delays
 * Shared by the packages and the RTL
 */
`ifndef CORE_SHELL_PARAMS_SVH
`define CORE_SHELL_PARAMS_SVH

// Data word and per-byte parity
`define CS_XLEN 32
`define CS_PAR_W 4

// Register file geometry
`define CS_REG_AW 5
`define CS_NUM_REGS 32

// Wishbone byte address, bits 6 to 2 pick the register
`define CS_WB_AW 7

// Shadow copy lag in cycles
`define CS_LOCKSTEP_DELAY 2

`endif

// File: hdl/core_shell_top.sv
/*
 * Core shell top level
 * Wishbone slave in front of a parity protected register file,
 * with a delayed shadow copy checked in lockstep
 */
`include "core_shell_params.svh"

module core_shell_top import rf_pkg::*, bus_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Wishbone classic slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  wb_addr_t             wb_adr_i,
  input  wb_sel_t              wb_sel_i,
  input  logic [`CS_XLEN-1:0]  wb_dat_i,
  input  logic [`CS_PAR_W-1:0] wb_par_i,
  output logic [`CS_XLEN-1:0]  wb_dat_o,
  output logic [`CS_PAR_W-1:0] wb_par_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,

  // Status
  output logic                 alert_minor_o,
  output logic                 alert_major_o,
  output logic                 core_sleep_o
);

  logic     rf_we;
  rf_addr_t rf_waddr;
  rf_word_t rf_wword;
  rf_addr_t rf_raddr;
  rf_word_t rf_rword;
  logic     rd_strobe;

  rf_access_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .wb_par_i     (wb_par_i),
    .wb_dat_o     (wb_dat_o),
    .wb_par_o     (wb_par_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wword_o   (rf_wword),
    .rf_raddr_o   (rf_raddr),
    .rf_rword_i   (rf_rword),
    .rd_strobe_o  (rd_strobe),
    .alert_minor_o(alert_minor_o),
    .core_sleep_o (core_sleep_o)
  );

  // Main copy
  reg_file u_reg_file (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .we_i   (rf_we),
    .waddr_i(rf_waddr),
    .wword_i(rf_wword),
    .raddr_i(rf_raddr),
    .rword_o(rf_rword)
  );

  lockstep_checker u_lockstep (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .we_i         (rf_we),
    .waddr_i      (rf_waddr),
    .wword_i      (rf_wword),
    .rd_strobe_i  (rd_strobe),
    .raddr_i      (rf_raddr),
    .rword_i      (rf_rword),
    .alert_major_o(alert_major_o)
  );

endmodule

// File: hdl/lockstep_checker.sv
/*
 * Lockstep checker with a delayed shadow register file
 * Flags a major alert on any read that the shadow disagrees with
 */
module lockstep_checker import rf_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  rf_word_t wword_i,
  input  logic     rd_strobe_i,
  input  rf_addr_t raddr_i,
  input  rf_word_t rword_i,
  output logic     alert_major_o
);

  rf_wreq_t wreq;
  rf_wreq_t wreq_dly;
  rf_rchk_t rchk;
  rf_rchk_t rchk_dly;
  rf_word_t shadow_word;
  logic     word_diff;
  logic     par_bad;

  assign wreq = '{en: we_i, addr: waddr_i, word: wword_i};
  assign rchk = '{valid: rd_strobe_i, addr: raddr_i, word: rword_i};

  // Same lag on both paths keeps the copies aligned
  lockstep_delay #(.payload_t(rf_wreq_t)) u_wreq_dly (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .in_i  (wreq),
    .out_o (wreq_dly)
  );

  lockstep_delay #(.payload_t(rf_rchk_t)) u_rchk_dly (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .in_i  (rchk),
    .out_o (rchk_dly)
  );

  // Shadow copy
  reg_file u_shadow_rf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .we_i   (wreq_dly.en),
    .waddr_i(wreq_dly.addr),
    .wword_i(wreq_dly.word),
    .raddr_i(rchk_dly.addr),
    .rword_o(shadow_word)
  );

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  assign word_diff = shadow_word != rchk_dly.word;
  assign par_bad   = calc_par(rchk_dly.word.data) != rchk_dly.word.par;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_major_o <= 1'b0;
    end else begin
      alert_major_o <= rchk_dly.valid & (word_diff | par_bad);
    end
  end

endmodule

// File: hdl/lockstep_delay.sv
/*
 * Fixed depth delay line for lockstep payloads
 */
`include "core_shell_params.svh"

module lockstep_delay #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t in_i,
  output payload_t out_o
);

  payload_t stage_q [`CS_LOCKSTEP_DELAY];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CS_LOCKSTEP_DELAY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= in_i;
      for (int i = 1; i < `CS_LOCKSTEP_DELAY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out_o = stage_q[`CS_LOCKSTEP_DELAY-1];

endmodule

// File: hdl/reg_file.sv
/*
 * Flop based register file, one write and one read port
 * Word zero is hard wired to zero data with zero parity
 */
`include "core_shell_params.svh"

module reg_file import rf_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  rf_word_t wword_i,
  input  rf_addr_t raddr_i,
  output rf_word_t rword_o
);

  rf_word_t regs [`CS_NUM_REGS];

  // Zero data has zero parity, so this is a valid word
  assign regs[0] = '0;

  for (genvar i = 1; i < `CS_NUM_REGS; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs[i] <= '0;
      end else if (we_i && (waddr_i == rf_addr_t'(i))) begin
        regs[i] <= wword_i;
      end
    end
  end

  // Combinational read
  assign rword_o = regs[raddr_i];

endmodule

// File: hdl/rf_access_ctrl.sv
/*
 * Wishbone slave control for the register file
 * Checks select and write parity, answers in one cycle,
 * and reports sleep and minor alerts
 */
`include "core_shell_params.svh"

module rf_access_ctrl import rf_pkg::*, bus_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  wb_addr_t             wb_adr_i,
  input  wb_sel_t              wb_sel_i,
  input  logic [`CS_XLEN-1:0]  wb_dat_i,
  input  logic [`CS_PAR_W-1:0] wb_par_i,
  output logic [`CS_XLEN-1:0]  wb_dat_o,
  output logic [`CS_PAR_W-1:0] wb_par_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,

  output logic                 rf_we_o,
  output rf_addr_t             rf_waddr_o,
  output rf_word_t             rf_wword_o,
  output rf_addr_t             rf_raddr_o,
  input  rf_word_t             rf_rword_i,
  output logic                 rd_strobe_o,

  output logic                 alert_minor_o,
  output logic                 core_sleep_o
);

  bus_state_e state_q;
  logic       req;
  logic       sel_ok;
  logic       bad_wpar;
  logic       req_err;
  logic       req_ok;
  rf_addr_t   reg_idx;

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////

  assign req      = wb_cyc_i & wb_stb_i & (state_q == IDLE);
  assign sel_ok   = &wb_sel_i;
  assign bad_wpar = wb_we_i & (calc_par(wb_dat_i) != wb_par_i);
  assign req_err  = req & (~sel_ok | bad_wpar);
  assign req_ok   = req & ~req_err;
  assign reg_idx  = wb_adr_i[`CS_WB_AW-1:2];

  // Writes to register 0 never reach the port
  assign rf_we_o    = req_ok & wb_we_i & (reg_idx != '0);
  assign rf_waddr_o = reg_idx;
  assign rf_wword_o = '{par: wb_par_i, data: wb_dat_i};
  assign rf_raddr_o = reg_idx;

  assign rd_strobe_o = req_ok & ~wb_we_i;

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      wb_ack_o      <= 1'b0;
      wb_err_o      <= 1'b0;
      alert_minor_o <= 1'b0;
    end else begin
      state_q       <= req ? RESP : IDLE;
      wb_ack_o      <= req_ok;
      wb_err_o      <= req_err;
      alert_minor_o <= req & bad_wpar;
    end
  end

  // Read data holds until the next good read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_dat_o <= '0;
      wb_par_o <= '0;
    end else if (rd_strobe_o) begin
      wb_dat_o <= rf_rword_i.data;
      wb_par_o <= rf_rword_i.par;
    end
  end

  assign core_sleep_o = (state_q == IDLE) & ~wb_cyc_i;

endmodule

// File: hdl/rf_pkg.sv
/*
 * Register storage and lockstep payload types
 * Also holds the even parity rule used on every data word
 */
`include "core_shell_params.svh"

package rf_pkg;

  typedef logic [`CS_REG_AW-1:0] rf_addr_t;

  // Data word carried with one parity bit per byte
  typedef struct packed {
    logic [`CS_PAR_W-1:0] par;
    logic [`CS_XLEN-1:0]  data;
  } rf_word_t;

  typedef struct packed {
    logic     en;
    rf_addr_t addr;
    rf_word_t word;
  } rf_wreq_t;

  typedef struct packed {
    logic     valid;
    rf_addr_t addr;
    rf_word_t word;
  } rf_rchk_t;

  // Each bit is the XOR of its byte
  function automatic logic [`CS_PAR_W-1:0] calc_par(logic [`CS_XLEN-1:0] data);
    logic [`CS_PAR_W-1:0] par;
    for (int i = 0; i < `CS_PAR_W; i++) begin
      par[i] = ^data[8*i +: 8];
    end
    return par;
  endfunction

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module core_shell_tb \
  -f filelist.f --Mdir obj_dir -o core_shell_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/core_shell_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

// File: verification/core_shell_asserts.sv
/*
 * Wishbone handshake and alert assertions for the core shell
 */
module core_shell_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic wb_err_i,
  input logic alert_minor_i,
  input logic alert_major_i
);

  ack_err_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_i && wb_err_i))
    else $error("ack and err are high together");

  // Open request without a response yet
  rsp_latency_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_i && wb_stb_i && !wb_ack_i && !wb_err_i) |=> (wb_ack_i || wb_err_i))
    else $error("no response one cycle after stb");

  rsp_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_ack_i || wb_err_i) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("response without a request");

  no_major_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !alert_major_i)
    else $error("lockstep major alert raised");

  minor_with_err_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_minor_i |-> wb_err_i)
    else $error("minor alert without err");

endmodule

bind core_shell_top core_shell_asserts u_asserts (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .wb_cyc_i     (wb_cyc_i),
  .wb_stb_i     (wb_stb_i),
  .wb_ack_i     (wb_ack_o),
  .wb_err_i     (wb_err_o),
  .alert_minor_i(alert_minor_o),
  .alert_major_i(alert_major_o)
);

// File: verification/core_shell_golden.txt
# Columns: name op(W/R) byte_addr sel data parity resp(A=ack E=err) expected_read_data
# Numbers are hex; the register index is byte_addr bits 6 to 2
wr_r5_good      W 14 f 12345678 4 A 00000000
rd_r5           R 14 f 00000000 0 A 12345678
wr_r1_good      W 04 f deadbeef 5 A 00000000
rd_r1           R 04 f 00000000 0 A deadbeef
wr_r0_drop      W 00 f cafef00d 5 A 00000000
rd_r0_zero      R 00 f 00000000 0 A 00000000
wr_r5_badpar    W 14 f 0badf00d 0 E 00000000
rd_r5_kept      R 14 f 00000000 0 A 12345678
wr_r1_badpar    W 04 f a5a5a5a5 1 E 00000000
rd_r1_kept      R 04 f 00000000 0 A deadbeef
wr_r1_sel_part  W 04 3 0000ffff 0 E 00000000
rd_r1_sel_kept  R 04 f 00000000 0 A deadbeef
rd_r1_sel_part  R 04 1 00000000 0 E 00000000
wr_r31_good     W 7c f ff000001 1 A 00000000
rd_r31          R 7c f 00000000 0 A ff000001
wr_r31_over     W 7c f a5a5a5a5 0 A 00000000
rd_r31_over     R 7c f 00000000 0 A a5a5a5a5
wr_r2_good      W 08 f 0000ffff 0 A 00000000
rd_r2           R 08 f 00000000 0 A 0000ffff
rd_r0_again     R 00 f 00000000 0 A 00000000

// File: verification/core_shell_tb.sv
/*
 * Core shell testbench
 * Replays the golden bus cycles, then random writes and reads against a model
 */
`include "core_shell_params.svh"

module core_shell_tb;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [`CS_WB_AW-1:0] wb_adr;
  logic [3:0]           wb_sel;
  logic [`CS_XLEN-1:0]  wb_dat_w;
  logic [`CS_PAR_W-1:0] wb_par_w;
  logic [`CS_XLEN-1:0]  wb_dat_r;
  logic [`CS_PAR_W-1:0] wb_par_r;
  logic                 wb_ack;
  logic                 wb_err;
  logic                 alert_minor;
  logic                 alert_major;
  logic                 core_sleep;

  int                   errors;
  int                   seed;
  logic [`CS_XLEN-1:0]  model [`CS_NUM_REGS];

  // Last bus response
  logic [`CS_XLEN-1:0]  rsp_dat;
  logic [`CS_PAR_W-1:0] rsp_par;
  logic                 rsp_ack;
  logic                 rsp_err;
  logic                 rsp_alert;

  core_shell_top DUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_sel_i     (wb_sel),
    .wb_dat_i     (wb_dat_w),
    .wb_par_i     (wb_par_w),
    .wb_dat_o     (wb_dat_r),
    .wb_par_o     (wb_par_r),
    .wb_ack_o     (wb_ack),
    .wb_err_o     (wb_err),
    .alert_minor_o(alert_minor),
    .alert_major_o(alert_major),
    .core_sleep_o (core_sleep)
  );

  always #4 clk = ~clk;

  // Even weight per byte plus its parity bit
  function automatic logic [3:0] byte_parity(input logic [31:0] d);
    return {^d[31:24], ^d[23:16], ^d[15:8], ^d[7:0]};
  endfunction

  task automatic check(input string name, input logic [35:0] expected,
                       input logic [35:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Shadow mismatches show up a few cycles after the read
  always @(negedge clk) begin
    if (rst_n) begin
      check("alert_major", 36'(0), 36'(alert_major));
    end
  end

  ////////////////////////////////////////
  // Reset and bus tasks
  ////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("reset_sleep", 36'(1), 36'(core_sleep));
    check("reset_resp", 36'(0), 36'({wb_ack, wb_err, alert_minor}));
    check("reset_rdata", 36'(0), {wb_par_r, wb_dat_r});
  endtask

  task automatic bus_cycle(input string name, input logic we, input logic [6:0] adr,
                           input logic [3:0] sel, input logic [31:0] dat,
                           input logic [3:0] par);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = dat;
    wb_par_w = par;
    rsp_ack  = 1'b0;
    rsp_err  = 1'b0;
    // Cycle open while the slave is still idle
    @(negedge clk);
    check({name, "_open_sleep"}, 36'(0), 36'(core_sleep));
    while (!rsp_ack && !rsp_err && n < 20) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      check({name, "_busy_sleep"}, 36'(0), 36'(core_sleep));
      rsp_ack = wb_ack;
      rsp_err = wb_err;
    end
    if (!rsp_ack && !rsp_err) begin
      errors++;
      $display("%s: no bus response within 20 cycles", name);
    end else begin
      check({name, "_latency"}, 36'(1), 36'(n));
    end
    rsp_alert = alert_minor;
    rsp_dat   = wb_dat_r;
    rsp_par   = wb_par_r;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    check({name, "_idle_sleep"}, 36'(1), 36'(core_sleep));
  endtask

  task automatic run_op(input string name, input logic we, input logic [6:0] adr,
                        input logic [3:0] sel, input logic [31:0] dat,
                        input logic [3:0] par, input logic exp_err,
                        input logic [31:0] exp_dat);
    logic exp_alert;
    exp_alert = we && (par !== byte_parity(dat));
    bus_cycle(name, we, adr, sel, dat, par);
    check({name, "_ack"}, 36'(!exp_err), 36'(rsp_ack));
    check({name, "_err"}, 36'(exp_err), 36'(rsp_err));
    check({name, "_alert"}, 36'(exp_alert), 36'(rsp_alert));
    if (!we && !exp_err) begin
      check({name, "_rdata"}, {byte_parity(exp_dat), exp_dat}, {rsp_par, rsp_dat});
    end
  endtask

  ////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////

  task automatic replay_golden();
    int          fd;
    int          cnt;
    string       line;
    string       name;
    string       op;
    string       rsp;
    logic [6:0]  adr;
    logic [3:0]  sel;
    logic [31:0] dat;
    logic [3:0]  par;
    logic [31:0] exp_dat;
    fd = $fopen("verification/core_shell_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the golden file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      // Lines starting with # describe the columns
      if (cnt > 0 && line.getc(0) != 8'h23) begin
        cnt = $sscanf(line, "%s %s %h %h %h %h %s %h",
                      name, op, adr, sel, dat, par, rsp, exp_dat);
        if (cnt == 8) begin
          run_op(name, op == "W", adr, sel, dat, par, rsp == "E", exp_dat);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic random_phase();
    logic [4:0]  idx;
    logic [4:0]  other;
    logic [31:0] dat;
    for (int i = 0; i < 24; i++) begin
      idx = 5'($random(seed));
      dat = $random(seed);
      run_op("rnd_wr", 1'b1, {idx, 2'b00}, 4'hf, dat, byte_parity(dat), 1'b0, 32'h0);
      if (idx != 5'd0) begin
        model[idx] = dat;
      end
      // Write data with bad parity is ignored on a read
      run_op("rnd_rd_same", 1'b0, {idx, 2'b00}, 4'hf, dat, ~byte_parity(dat),
             1'b0, model[idx]);
      other = 5'($random(seed));
      run_op("rnd_rd_any", 1'b0, {other, 2'b00}, 4'hf, 32'h0, 4'h0, 1'b0, model[other]);
    end
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    wb_par_w = '0;
    errors   = 0;
    seed     = 18;
    for (int i = 0; i < `CS_NUM_REGS; i++) begin
      model[i] = '0;
    end
    apply_reset();
    replay_golden();
    // Fresh register contents for the model
    apply_reset();
    random_phase();
    repeat (4) @(posedge clk);
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
